/* dmss_consts.svh */
//////////////////////////////////////////////////////////////////////
// Data memory subsystem constants
//   memory size in bytes
//   poison word for conflicted loads and stage address reset
//   console store address
//////////////////////////////////////////////////////////////////////

`ifndef DMSS_CONSTS_SVH
`define DMSS_CONSTS_SVH

// Memory size, power of two, multiple of four
`define DMSS_SIZE_BYTES 4096

// Returned while a load waits on a store to the same word
`define DMSS_POISON 32'hDEADBEEF

// Committed stores here go to the console, not memory
`define DMSS_CONSOLE_ADDR 32'hFFFF_FFFF

`endif

/* dmss_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Data memory subsystem package
//   address, word and byte types
//   pipeline stage request struct
//////////////////////////////////////////////////////////////////////

package dmss_pkg;

    // Physical byte address, no translation
    typedef logic [31:0] paddr_t;

    // Data word, little endian in memory
    typedef logic [31:0] word_t;

    // One memory byte, also the console character
    typedef logic [7:0] byte_t;

    // Content of every pipeline stage register
    typedef struct packed {
        logic   load;   // Load in this stage
        logic   store;  // Store in this stage
        paddr_t addr;   // Byte address as requested
    } req_t;

endpackage

/* dmss_if.sv */
//////////////////////////////////////////////////////////////////////
// Interfaces inside the data memory subsystem
//   dmss_mem_if      pipe to memory, comb read and edge write
//   dmss_console_if  pipe to console sink
//////////////////////////////////////////////////////////////////////

interface dmss_mem_if;

    dmss_pkg::paddr_t rd_addr;  // Word aligned read address
    dmss_pkg::word_t  rd_data;  // Combinational read data
    logic             wr_en;    // Write at next rising edge
    dmss_pkg::paddr_t wr_addr;  // Word aligned write address
    dmss_pkg::word_t  wr_data;

    modport pipe (
        output rd_addr,
        input  rd_data,
        output wr_en,
        output wr_addr,
        output wr_data
    );

    modport mem (
        input  rd_addr,
        output rd_data,
        input  wr_en,
        input  wr_addr,
        input  wr_data
    );

endinterface

interface dmss_console_if;

    logic            con_we;     // Committed console store this cycle
    dmss_pkg::byte_t con_data;   // Low byte of the store data
    logic            con_valid;  // Console store in stage 2, commit or not

    modport pipe (output con_we, output con_data, output con_valid);

    modport sink (input con_we, input con_data, input con_valid);

endinterface

/* dmss_mem.sv */
//////////////////////////////////////////////////////////////////////
// Data memory
//   byte array, word read port, word write port
//   index is the word address modulo the memory size
//////////////////////////////////////////////////////////////////////

`include "dmss_consts.svh"

module dmss_mem (
    input logic     clk,
    dmss_mem_if.mem mem
);

    localparam int AW = $clog2(`DMSS_SIZE_BYTES);  // Byte index width

    dmss_pkg::byte_t mem_q [`DMSS_SIZE_BYTES];  // No reset, loaded by stores

    logic [AW-1:0] rd_idx;
    logic [AW-1:0] wr_idx;

    // Drop upper address bits and force word alignment
    assign rd_idx = {mem.rd_addr[AW-1:2], 2'b00};
    assign wr_idx = {mem.wr_addr[AW-1:2], 2'b00};

    // Combinational read, byte 0 in the low lane
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            mem.rd_data[8*i +: 8] = mem_q[rd_idx + AW'(i)];
        end
    end

    // All four bytes on every write
    always_ff @(posedge clk) begin
        if (mem.wr_en) begin
            for (int i = 0; i < 4; i++) begin
                mem_q[wr_idx + AW'(i)] <= mem.wr_data[8*i +: 8];  // Little endian
            end
        end
    end

endmodule

/* dmss_pipe.sv */
//////////////////////////////////////////////////////////////////////
// Data memory request pipeline
//   stage 0 capture under stall, stage 1 load response
//   stage 2 store commit to memory or console
//   load behind store conflict detection and poison
//////////////////////////////////////////////////////////////////////

`include "dmss_consts.svh"

module dmss_pipe (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             req_load,
    input  logic             req_store,
    input  dmss_pkg::paddr_t req_addr,
    input  logic             req_stall,
    output dmss_pkg::word_t  rsp_load_data,
    output logic             rsp_ready,
    input  logic             store_commit,
    input  dmss_pkg::word_t  store_data,
    dmss_mem_if.pipe         mem,
    dmss_console_if.pipe     con
);

    // Empty stage, poisoned address
    localparam dmss_pkg::req_t REQ_IDLE = '{load: 1'b0, store: 1'b0, addr: `DMSS_POISON};

    dmss_pkg::req_t s0_q;  // M1
    dmss_pkg::req_t s1_q;  // M2
    dmss_pkg::req_t s2_q;  // WB

    dmss_pkg::paddr_t s1_word;
    dmss_pkg::paddr_t s2_word;
    logic             conflict;
    logic             s2_is_con;   // Stage 2 targets the console
    logic             s2_commit;   // Store in stage 2 is committed

    // Stage 0, held by the requester
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s0_q <= REQ_IDLE;
        end else if (!req_stall) begin
            s0_q <= '{load: req_load, store: req_store, addr: req_addr};
        end
    end

    // Stage 1, only the conflict holds it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_q <= REQ_IDLE;
        end else if (!conflict) begin
            s1_q <= s0_q;
        end
    end

    // Stage 2 never stalls
    // On a conflict the held load moves in, so no store here next cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s2_q <= REQ_IDLE;
        end else begin
            s2_q <= s1_q;
        end
    end

    assign s1_word = {s1_q.addr[31:2], 2'b00};
    assign s2_word = {s2_q.addr[31:2], 2'b00};

    // Load reading a word the older store has not written yet
    assign conflict = s1_q.load && s2_q.store && (s1_word == s2_word);

    // Load response
    assign mem.rd_addr    = s1_word;
    assign rsp_load_data  = conflict ? `DMSS_POISON : mem.rd_data;
    assign rsp_ready      = !conflict;  // No other stall source

    // Store routing
    assign s2_is_con = (s2_q.addr == `DMSS_CONSOLE_ADDR);
    assign s2_commit = s2_q.store && store_commit;

    assign mem.wr_en   = s2_commit && !s2_is_con;
    assign mem.wr_addr = s2_word;
    assign mem.wr_data = store_data;

    assign con.con_we    = s2_commit && s2_is_con;
    assign con.con_data  = store_data[7:0];  // One character per store
    assign con.con_valid = s2_q.store && s2_is_con;

    // Requester never asks for both at once
    a_single_req : assert property (
        @(posedge clk) disable iff (!rst_n)
        !req_stall |-> !(req_load && req_store)
    );

    // Requester must stall while ready is low
    a_s0_hold : assert property (
        @(posedge clk) disable iff (!rst_n)
        !rsp_ready |=> $stable(s0_q)
    );

    // Held load sees no store in stage 2 the next cycle
    a_conflict_once : assert property (
        @(posedge clk) disable iff (!rst_n)
        conflict |=> !conflict
    );

endmodule

/* dmss_console.sv */
//////////////////////////////////////////////////////////////////////
// Console sink
//   registers committed console stores as a byte strobe
//////////////////////////////////////////////////////////////////////

module dmss_console (
    input  logic            clk,
    input  logic            rst_n,
    dmss_console_if.sink    con,
    output logic            con_valid,
    output dmss_pkg::byte_t con_byte
);

    // One cycle strobe per committed store
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            con_valid <= 1'b0;
        end else begin
            con_valid <= con.con_we;
        end
    end

    always_ff @(posedge clk) begin
        if (con.con_we) begin
            con_byte <= con.con_data;  // Held until the next store
        end
    end

    // Stage 2 is cleared after the first reset edge
    a_no_we_in_reset : assert property (
        @(posedge clk) (!rst_n && $past(!rst_n)) |-> !con.con_we
    );

endmodule

/* dmss_top.sv */
//////////////////////////////////////////////////////////////////////
// Data memory subsystem top level
//   plain core ports
//   pipeline, memory and console sink on two interfaces
//////////////////////////////////////////////////////////////////////

module dmss_top (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             req_load,
    input  logic             req_store,
    input  dmss_pkg::paddr_t req_addr,
    input  logic             req_stall,
    output dmss_pkg::word_t  rsp_load_data,
    output logic             rsp_ready,
    input  logic             store_commit,
    input  dmss_pkg::word_t  store_data,
    output logic             con_valid,
    output dmss_pkg::byte_t  con_byte
);

    dmss_mem_if     mem_bus ();  // Pipe to memory
    dmss_console_if con_bus ();  // Pipe to console sink

    dmss_pipe u_pipe (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_load      (req_load),
        .req_store     (req_store),
        .req_addr      (req_addr),
        .req_stall     (req_stall),
        .rsp_load_data (rsp_load_data),
        .rsp_ready     (rsp_ready),
        .store_commit  (store_commit),
        .store_data    (store_data),
        .mem           (mem_bus),
        .con           (con_bus)
    );

    dmss_mem u_mem (
        .clk (clk),
        .mem (mem_bus)
    );

    dmss_console u_console (
        .clk       (clk),
        .rst_n     (rst_n),
        .con       (con_bus),
        .con_valid (con_valid),
        .con_byte  (con_byte)
    );

endmodule

/* tb_dmss.sv */
//////////////////////////////////////////////////////////////////////
// Testbench for the data memory subsystem
//   clock, reset, warm-up stores and random load/store traffic
//   shadow model of the three stages and the byte memory
//   compare tasks per result kind, watchdog
//////////////////////////////////////////////////////////////////////

`include "dmss_consts.svh"

module tb_dmss;

    localparam int PERIOD    = 4;
    localparam int N_WARM    = 8;     // Warm-up stores, two per window word
    localparam int N_RAND    = 1000;
    localparam int WIN_WORDS = 4;     // Small window, frequent conflicts
    localparam dmss_pkg::paddr_t WIN_BASE   = 32'h0000_0FF0;  // Last word shares the console index
    localparam dmss_pkg::paddr_t PAGE_ALIAS = 32'h0001_0000;  // Same memory word
    localparam dmss_pkg::req_t   EMPTY = '{load: 1'b0, store: 1'b0, addr: `DMSS_POISON};

    logic             clk;
    logic             rst_n;
    logic             req_load;
    logic             req_store;
    dmss_pkg::paddr_t req_addr;
    logic             req_stall;
    dmss_pkg::word_t  rsp_load_data;
    logic             rsp_ready;
    logic             store_commit;
    dmss_pkg::word_t  store_data;
    logic             con_valid;
    dmss_pkg::byte_t  con_byte;

    // Shadow pipeline and memory
    dmss_pkg::req_t  m_s0;
    dmss_pkg::req_t  m_s1;
    dmss_pkg::req_t  m_s2;
    dmss_pkg::byte_t m_mem [`DMSS_SIZE_BYTES];
    bit              m_known [`DMSS_SIZE_BYTES];  // Byte written by a commit
    logic            m_con_valid;
    dmss_pkg::byte_t m_con_byte;
    bit              in_warmup;
    int              n_con_exp;
    int              n_con_dut;
    int              n_conflict;
    int              n_uncommitted;
    int              n_loads_checked;

    dmss_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Simulation FAILED");
        $fatal(1, "dmss testbench stopped at %0t", $time);
    endtask

    initial begin
        #((N_WARM + N_RAND) * 8 * PERIOD);
        fail_run("Watchdog expired, the request sequence did not finish in time");
    end

    task automatic check_word(input string name, input dmss_pkg::word_t exp,
                              input dmss_pkg::word_t act);
        if (act !== exp)
            fail_run($sformatf("ERROR %s expected %08h actual %08h", name, exp, act));
    endtask

    task automatic check_byte(input string name, input dmss_pkg::byte_t exp,
                              input dmss_pkg::byte_t act);
        if (act !== exp)
            fail_run($sformatf("ERROR %s expected %02h actual %02h", name, exp, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
            fail_run($sformatf("ERROR %s expected %b actual %b", name, exp, act));
    endtask

    // Word-aligned byte index, modulo the memory size
    function automatic int word_index(input dmss_pkg::paddr_t addr);
        return int'({addr[31:2], 2'b00} % 32'(`DMSS_SIZE_BYTES));
    endfunction

    function automatic dmss_pkg::word_t model_word(input dmss_pkg::paddr_t addr);
        dmss_pkg::word_t w;
        int              idx;
        idx = word_index(addr);
        for (int i = 0; i < 4; i++)
            w[8*i +: 8] = m_mem[idx + i];  // Byte 0 in the low lane
        return w;
    endfunction

    function automatic bit word_known(input dmss_pkg::paddr_t addr);
        int idx;
        idx = word_index(addr);
        return m_known[idx] && m_known[idx + 1] && m_known[idx + 2] && m_known[idx + 3];
    endfunction

    // Load in stage 1 behind a store to the same word in stage 2
    function automatic bit stage_conflict(input dmss_pkg::req_t s1, input dmss_pkg::req_t s2);
        return s1.load && s2.store && (s1.addr[31:2] == s2.addr[31:2]);
    endfunction

    // Advance the model by one rising edge, inputs as driven in the cycle
    task automatic model_edge();
        bit conf;
        int idx;
        conf        = stage_conflict(m_s1, m_s2);
        m_con_valid = 1'b0;
        if (m_s2.store && store_commit) begin
            if (m_s2.addr == `DMSS_CONSOLE_ADDR) begin
                m_con_valid = 1'b1;          // Pulse next cycle
                m_con_byte  = store_data[7:0];
                n_con_exp++;
            end else begin
                idx = word_index(m_s2.addr);
                for (int i = 0; i < 4; i++) begin
                    m_mem[idx + i]   = store_data[8*i +: 8];
                    m_known[idx + i] = 1'b1;
                end
            end
        end else if (m_s2.store) begin
            n_uncommitted++;
        end
        if (conf)
            n_conflict++;
        m_s2 = m_s1;                         // Stage 2 never holds
        if (!conf)
            m_s1 = m_s0;
        if (!req_stall)
            m_s0 = '{load: req_load, store: req_store, addr: req_addr};
    endtask

    task automatic check_outputs();
        bit conf;
        conf = stage_conflict(m_s1, m_s2);
        check_bit("rsp_ready", !conf, rsp_ready);
        if (conf) begin
            check_word("conflict poison", `DMSS_POISON, rsp_load_data);
        end else if (m_s1.load && word_known(m_s1.addr)) begin
            check_word("load data", model_word(m_s1.addr), rsp_load_data);
            n_loads_checked++;
        end
        check_bit("con_valid", m_con_valid, con_valid);
        if (m_con_valid)
            check_byte("con_byte", m_con_byte, con_byte);
        if (con_valid === 1'b1)
            n_con_dut++;
    endtask

    // Present one request until stage 0 takes it, one cycle per try
    task automatic run_request(input logic ld, input logic st, input dmss_pkg::paddr_t addr);
        bit taken;
        taken = 1'b0;
        while (!taken) begin
            req_stall = !rsp_ready;          // Back-pressure from the DUT
            req_load  = ld;
            req_store = st;
            req_addr  = addr;
            if (m_s2.store)
                store_commit = in_warmup || ($urandom_range(0, 3) != 0);
            else
                store_commit = 1'($urandom_range(0, 1));  // No store, must not write
            store_data = $urandom();
            taken      = !req_stall;
            @(posedge clk);
            #1;
            model_edge();
            check_outputs();
        end
    endtask

    function automatic dmss_pkg::paddr_t pick_addr();
        dmss_pkg::paddr_t a;
        a = WIN_BASE + 4 * $urandom_range(0, WIN_WORDS - 1) + $urandom_range(0, 3);
        if ($urandom_range(0, 7) == 0)
            a = a + PAGE_ALIAS;
        return a;
    endfunction

    initial begin
        dmss_pkg::paddr_t addr;
        int unsigned      pick;
        rst_n        = 1'b0;
        req_load     = 1'b0;
        req_store    = 1'b0;
        req_addr     = '0;
        req_stall    = 1'b0;
        store_commit = 1'b0;
        store_data   = '0;
        void'($urandom(32'hc37fc614));
        m_s0         = EMPTY;
        m_s1         = EMPTY;
        m_s2         = EMPTY;
        m_con_valid  = 1'b0;
        in_warmup    = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_bit("reset rsp_ready", 1'b1, rsp_ready);
        check_bit("reset con_valid", 1'b0, con_valid);
        for (int n = 0; n < N_WARM; n++)
            run_request(1'b0, 1'b1, WIN_BASE + 4 * (n % WIN_WORDS));
        in_warmup = 1'b0;
        for (int n = 0; n < N_RAND; n++) begin
            pick = $urandom_range(0, 99);
            addr = pick_addr();
            if (pick < 40) begin
                run_request(1'b1, 1'b0, addr);
            end else if (pick < 75) begin
                if ($urandom_range(0, 19) == 0)
                    addr = `DMSS_CONSOLE_ADDR;   // About 5% of stores
                run_request(1'b0, 1'b1, addr);
            end else begin
                run_request(1'b0, 1'b0, addr);
            end
        end
        repeat (4) run_request(1'b0, 1'b0, WIN_BASE);  // Drain stages 1 and 2
        check_word("console pulse count", dmss_pkg::word_t'(n_con_exp),
                   dmss_pkg::word_t'(n_con_dut));
        if (n_conflict == 0 || n_con_dut == 0 || n_uncommitted == 0 || n_loads_checked == 0) begin
            fail_run("Random traffic missed a conflict, console store, uncommitted store or load");
        end else begin
            $display("Loads %0d, conflicts %0d, console bytes %0d, uncommitted stores %0d",
                     n_loads_checked, n_conflict, n_con_dut, n_uncommitted);
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

/* files.f */
+incdir+.
dmss_pkg.sv
dmss_if.sv
dmss_mem.sv
dmss_pipe.sv
dmss_console.sv
dmss_top.sv
tb_dmss.sv

/* run.sh */
#!/bin/sh
# Verilator build and run of tb_dmss, verdict taken from the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_dmss -f files.f -o tb_dmss
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_dmss > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation run exited with status $status"
    exit 1
fi

if grep -q "Simulation PASSED" "$LOG"; then
    echo "Result: pass"
    exit 0
else
    echo "Result: fail, see $LOG"
    exit 1
fi
